// ==== Bender.yml ====
package:
  name: fpu_fma

sources:
  - fpu_pkg.sv
  - fma_issue.sv
  - fma_lane.sv
  - fma_collect.sv
  - fpu_fma_top.sv
  - target: test
    files:
      - tb_fpu_fma.sv

// ==== fma_collect.sv ====
// FMA result collector that picks the finishing lane, registers it and keeps sticky flags
`timescale 1ns/1ps
`default_nettype none

module fma_collect (
	input  logic                                         clk,
	input  logic                                         rst,
	input  logic [fpu_pkg::NUM_LANES-1:0]                done,
	input  logic [fpu_pkg::NUM_LANES-1:0][63:0]          lane_result,
	input  fpu_pkg::cause_t [fpu_pkg::NUM_LANES-1:0]     lane_cause,
	input  fpu_pkg::reg_tag_t [fpu_pkg::NUM_LANES-1:0]   lane_rd,
	input  logic                                         flags_clear,
	output logic                                         res_valid,
	output logic [63:0]                                  res_value,
	output fpu_pkg::reg_tag_t                            res_rd,
	output fpu_pkg::cause_t                              res_cause,
	output logic [fpu_pkg::FLAG_W-1:0]                   flags
);

	logic any_done;
	logic [63:0] sel_result;
	logic [2:0] sel_cause;
	fpu_pkg::reg_tag_t sel_rd;
	logic [fpu_pkg::FLAG_W-1:0] new_flags;

	// ==============================
	// Lane select
	// ==============================

	// done is one-hot, so an AND-OR mux picks the finishing lane
	always_comb begin
		sel_result = '0;
		sel_cause = '0;
		sel_rd = '0;
		for (int k = 0; k < fpu_pkg::NUM_LANES; k++) begin
			if (done[k]) begin
				sel_result = sel_result | lane_result[k];
				sel_cause = sel_cause | lane_cause[k];
				sel_rd = sel_rd | lane_rd[k];
			end
		end
	end

	assign any_done = |done;

	// Only the winning cause of each result reaches the flags
	always_comb begin
		new_flags = '0;
		if (any_done) begin
			case (fpu_pkg::cause_t'(sel_cause))
				fpu_pkg::CAUSE_INVALID: new_flags[fpu_pkg::FLAG_INVALID] = 1'b1;
				fpu_pkg::CAUSE_OVERFLOW: new_flags[fpu_pkg::FLAG_OVERFLOW] = 1'b1;
				fpu_pkg::CAUSE_UNDERFLOW: new_flags[fpu_pkg::FLAG_UNDERFLOW] = 1'b1;
				fpu_pkg::CAUSE_INEXACT: new_flags[fpu_pkg::FLAG_INEXACT] = 1'b1;
				default: new_flags = '0;
			endcase
		end
	end

	// ==============================
	// Output and flag registers
	// ==============================

	always_ff @(posedge clk) begin
		if (rst) begin
			res_valid <= 1'b0;
			flags <= '0;
		end else begin
			res_valid <= any_done;
			// A clear in the same cycle as a new cause still records the new cause
			if (flags_clear)
				flags <= new_flags;
			else
				flags <= flags | new_flags;
		end
	end

	always_ff @(posedge clk) begin
		if (any_done) begin
			res_value <= sel_result;
			res_rd <= sel_rd;
			res_cause <= fpu_pkg::cause_t'(sel_cause);
		end
	end

	// Equal lane latency and round-robin issue allow one finisher per cycle at most
	a_done_onehot: assert property (@(posedge clk) disable iff (rst) $onehot0(done));

endmodule

`default_nettype wire

// ==== fma_issue.sv ====
// FMA issue stage that decodes the opcode, prepares operands and dispatches round-robin
`timescale 1ns/1ps
`default_nettype none

module fma_issue (
	input  logic                                clk,
	input  logic                                rst,
	input  logic                                in_valid,
	input  fpu_pkg::fpu_op_t                    in_op,
	input  fpu_pkg::reg_tag_t                   in_rd,
	input  logic [63:0]                         in_a,
	input  logic [63:0]                         in_b,
	input  logic [63:0]                         in_c,
	output logic [fpu_pkg::NUM_LANES-1:0]       start,
	output logic [63:0]                         op_a,
	output logic [63:0]                         op_b,
	output logic [63:0]                         op_c,
	output fpu_pkg::reg_tag_t                   op_rd
);

	// Operands after neutral substitution and sign changes
	logic [63:0] a_n;
	logic [63:0] b_n;
	logic [63:0] c_n;

	// Lane that receives the next operation
	logic [fpu_pkg::LANE_IDX_W-1:0] ptr;

	// ==============================
	// Opcode decode
	// ==============================

	// Every opcode becomes a times b plus c
	// FADD and FSUB replace b with 1.0 and add or subtract c
	// FMUL adds negative zero so a negative zero product keeps its sign
	always_comb begin
		a_n = in_a;
		b_n = in_b;
		c_n = in_c;
		case (in_op)
			fpu_pkg::OP_FADD: begin
				b_n = fpu_pkg::F64_ONE;
			end
			fpu_pkg::OP_FSUB: begin
				b_n = fpu_pkg::F64_ONE;
				c_n[63] = ~in_c[63];
			end
			fpu_pkg::OP_FMUL: begin
				c_n = fpu_pkg::F64_NEG_ZERO;
			end
			fpu_pkg::OP_FMSUB: begin
				c_n[63] = ~in_c[63];
			end
			// Negating a and c negates the whole fused result
			fpu_pkg::OP_FNMADD: begin
				a_n[63] = ~in_a[63];
				c_n[63] = ~in_c[63];
			end
			default: begin
			end
		endcase
	end

	// ==============================
	// Dispatch
	// ==============================

	// One start pulse per valid operation, then the pointer moves on
	always_ff @(posedge clk) begin
		if (rst) begin
			start <= '0;
			ptr <= '0;
		end else begin
			start <= '0;
			if (in_valid) begin
				start[ptr] <= 1'b1;
				if (ptr == fpu_pkg::LANE_IDX_W'(fpu_pkg::NUM_LANES - 1))
					ptr <= '0;
				else
					ptr <= ptr + 1'b1;
			end
		end
	end

	// Shared operand buses, a lane only looks at them during its own start
	always_ff @(posedge clk) begin
		if (in_valid) begin
			op_a <= a_n;
			op_b <= b_n;
			op_c <= c_n;
			op_rd <= in_rd;
		end
	end

	// Two lanes must never capture the same operation
	a_start_onehot: assert property (@(posedge clk) disable iff (rst) $onehot0(start));

endmodule

`default_nettype wire

// ==== fma_lane.sv ====
// Iterative double-precision fused multiply-add lane with one rounding and exception detection
`timescale 1ns/1ps
`default_nettype none

module fma_lane (
	input  logic              clk,
	input  logic              rst,
	input  logic              start,
	input  logic [63:0]       a,
	input  logic [63:0]       b,
	input  logic [63:0]       c,
	input  fpu_pkg::reg_tag_t rd,
	output logic              done,
	output logic              busy,
	output logic [63:0]       result,
	output fpu_pkg::cause_t   cause,
	output fpu_pkg::reg_tag_t result_rd
);

	// Step 1 runs on the start edge out of ST_IDLE, the other states hold steps 2 to 4
	typedef enum logic [1:0] {ST_IDLE, ST_MUL, ST_ADD, ST_RND} state_t;
	state_t st;

	// Step 1 fields straight from the operand buses
	logic [fpu_pkg::EXP_W-1:0] a_exp, b_exp, c_exp;
	logic [fpu_pkg::MAN_W-1:0] a_man, b_man, c_man;
	logic a_zero, b_zero, c_zero;
	logic a_inf, b_inf, c_inf;
	logic a_nan, b_nan, c_nan;
	logic any_snan, p_sign, p_zero, p_inf;
	logic spec_v_n;
	logic [63:0] spec_res_n;
	fpu_pkg::cause_t spec_cause_n;

	// Registers written by step 1
	logic s1_sp, s1_sc, s1_c_zero;
	logic signed [13:0] s1_ep, s1_ec;
	logic [52:0] s1_ma, s1_mb, s1_mc;
	logic spec_v;
	logic [63:0] spec_res;
	fpu_pkg::cause_t spec_cause;

	// Step 2 exact significand product, two integer bits above the point at 104
	logic [105:0] prod;

	// Step 3 signals and registers, point sits after bit 106 of the 110-bit frame
	logic c_big;
	logic [13:0] shamt;
	logic [109:0] p_al, c_al, mag_n;
	logic sign_n;
	logic [109:0] mag;
	logic sum_sign;
	logic signed [13:0] eref;
	logic [6:0] lz;

	// Step 4 signals
	logic [109:0] norm;
	logic g_bit, s_bit;
	logic [53:0] rnd;
	logic signed [13:0] er;
	logic [fpu_pkg::MAN_W-1:0] frac;
	logic [63:0] res_n;
	fpu_pkg::cause_t cause_n;

	// Right shift that folds every lost bit into bit 0
	function automatic logic [109:0] shr_sticky(input logic [109:0] v, input logic [13:0] d);
		logic [109:0] s;
		logic lost;
		if (d >= 110) begin
			s = '0;
			lost = |v;
		end else begin
			s = v >> d;
			lost = ((s << d) != v);
		end
		return {s[109:1], s[0] | lost};
	endfunction

	// Leading zero count over the whole frame
	function automatic logic [6:0] lzc(input logic [109:0] v);
		logic [6:0] n;
		logic found;
		n = '0;
		found = 1'b0;
		for (int i = 109; i >= 0; i--) begin
			if (!found) begin
				if (v[i])
					found = 1'b1;
				else
					n = n + 1'b1;
			end
		end
		return n;
	endfunction

	// ==============================
	// Step 1: unpack and classify
	// ==============================

	assign a_exp = a[fpu_pkg::MAN_W +: fpu_pkg::EXP_W];
	assign b_exp = b[fpu_pkg::MAN_W +: fpu_pkg::EXP_W];
	assign c_exp = c[fpu_pkg::MAN_W +: fpu_pkg::EXP_W];
	assign a_man = a[fpu_pkg::MAN_W-1:0];
	assign b_man = b[fpu_pkg::MAN_W-1:0];
	assign c_man = c[fpu_pkg::MAN_W-1:0];

	// A zero exponent means zero, subnormal mantissas are ignored
	assign a_zero = (a_exp == '0);
	assign b_zero = (b_exp == '0);
	assign c_zero = (c_exp == '0);
	assign a_inf = (&a_exp) && (a_man == '0);
	assign b_inf = (&b_exp) && (b_man == '0);
	assign c_inf = (&c_exp) && (c_man == '0);
	assign a_nan = (&a_exp) && (a_man != '0);
	assign b_nan = (&b_exp) && (b_man != '0);
	assign c_nan = (&c_exp) && (c_man != '0);
	// A NaN with the quiet bit clear is signaling
	assign any_snan = (a_nan && !a_man[51]) || (b_nan && !b_man[51]) || (c_nan && !c_man[51]);
	assign p_sign = a[63] ^ b[63];
	assign p_zero = a_zero || b_zero;
	assign p_inf = a_inf || b_inf;

	// Cases that never need the arithmetic path
	always_comb begin
		spec_v_n = 1'b1;
		spec_res_n = fpu_pkg::F64_QNAN;
		spec_cause_n = fpu_pkg::CAUSE_NONE;
		if (a_nan || b_nan || c_nan) begin
			if (any_snan)
				spec_cause_n = fpu_pkg::CAUSE_INVALID;
		end else if ((a_inf && b_zero) || (a_zero && b_inf)) begin
			spec_cause_n = fpu_pkg::CAUSE_INVALID;
		end else if (p_inf && c_inf && (p_sign != c[63])) begin
			spec_cause_n = fpu_pkg::CAUSE_INVALID;
		end else if (p_inf) begin
			spec_res_n = {p_sign, {fpu_pkg::EXP_W{1'b1}}, {fpu_pkg::MAN_W{1'b0}}};
		end else if (c_inf) begin
			spec_res_n = {c[63], {fpu_pkg::EXP_W{1'b1}}, {fpu_pkg::MAN_W{1'b0}}};
		end else if (p_zero && c_zero) begin
			// Zero plus zero is negative only when both are negative
			spec_res_n = {p_sign & c[63], 63'b0};
		end else if (p_zero) begin
			spec_res_n = c;
		end else begin
			spec_v_n = 1'b0;
		end
	end

	// ==============================
	// Step 3: align, add, count
	// ==============================

	// The larger exponent becomes the reference and the other side shifts right
	assign c_big = !s1_c_zero && (s1_ec > s1_ep);
	assign shamt = c_big ? 14'(s1_ec - s1_ep) : 14'(s1_ep - s1_ec);
	assign p_al = c_big ? shr_sticky({2'b00, prod, 2'b00}, shamt) : {2'b00, prod, 2'b00};
	assign c_al = c_big ? {3'b000, s1_mc, 54'b0} : shr_sticky({3'b000, s1_mc, 54'b0}, shamt);

	always_comb begin
		if (s1_sp == s1_sc) begin
			mag_n = p_al + c_al;
			sign_n = s1_sp;
		end else if (p_al >= c_al) begin
			mag_n = p_al - c_al;
			sign_n = s1_sp;
		end else begin
			mag_n = c_al - p_al;
			sign_n = s1_sc;
		end
		// Exact cancellation gives positive zero under round to nearest
		if (mag_n == '0)
			sign_n = 1'b0;
	end

	// ==============================
	// Step 4: normalize, round, pack
	// ==============================

	assign norm = mag << lz;
	assign g_bit = norm[56];
	assign s_bit = |norm[55:0];
	// Round half to even on the 53-bit significand
	assign rnd = {1'b0, norm[109:57]} + 54'(g_bit & (s_bit | norm[57]));
	assign er = eref + 14'sd3 - $signed({7'b0, lz}) + $signed({13'b0, rnd[53]});
	// A carry out of the rounding leaves every fraction bit at zero
	assign frac = rnd[51:0];

	always_comb begin
		res_n = {sum_sign, er[10:0], frac};
		cause_n = (g_bit | s_bit) ? fpu_pkg::CAUSE_INEXACT : fpu_pkg::CAUSE_NONE;
		if (spec_v) begin
			res_n = spec_res;
			cause_n = spec_cause;
		end else if (mag == '0) begin
			res_n = '0;
			cause_n = fpu_pkg::CAUSE_NONE;
		end else if (er >= 14'sd2047) begin
			res_n = {sum_sign, {fpu_pkg::EXP_W{1'b1}}, {fpu_pkg::MAN_W{1'b0}}};
			cause_n = fpu_pkg::CAUSE_OVERFLOW;
		end else if (er <= 14'sd0) begin
			// Tiny results flush to a signed zero
			res_n = {sum_sign, 63'b0};
			cause_n = fpu_pkg::CAUSE_UNDERFLOW;
		end
	end

	// ==============================
	// Sequencer and datapath regs
	// ==============================

	assign busy = (st != ST_IDLE);

	always_ff @(posedge clk) begin
		if (rst) begin
			st <= ST_IDLE;
			done <= 1'b0;
		end else begin
			done <= 1'b0;
			case (st)
				ST_IDLE: if (start) st <= ST_MUL;
				ST_MUL: st <= ST_ADD;
				ST_ADD: st <= ST_RND;
				default: begin
					st <= ST_IDLE;
					done <= 1'b1;
				end
			endcase
		end
	end

	always_ff @(posedge clk) begin
		case (st)
			ST_IDLE: begin
				if (start) begin
					s1_sp <= p_sign;
					s1_sc <= c[63];
					s1_ep <= 14'(a_exp) + 14'(b_exp) - 14'(fpu_pkg::EXP_BIAS);
					s1_ec <= 14'(c_exp);
					s1_ma <= {1'b1, a_man};
					s1_mb <= {1'b1, b_man};
					s1_mc <= c_zero ? '0 : {1'b1, c_man};
					s1_c_zero <= c_zero;
					spec_v <= spec_v_n;
					spec_res <= spec_res_n;
					spec_cause <= spec_cause_n;
					result_rd <= rd;
				end
			end
			ST_MUL: prod <= s1_ma * s1_mb;
			ST_ADD: begin
				mag <= mag_n;
				sum_sign <= sign_n;
				eref <= c_big ? s1_ec : s1_ep;
				lz <= lzc(mag_n);
			end
			default: begin
				result <= res_n;
				cause <= cause_n;
			end
		endcase
	end

	// The issue rotation must leave each lane idle before starting it again
	a_no_start_busy: assert property (@(posedge clk) disable iff (rst) start |-> !busy);
	// Fixed latency keeps the results in issue order across lanes
	a_done_latency: assert property (@(posedge clk) disable iff (rst)
		start |-> ##(fpu_pkg::LANE_CYCLES) done);

endmodule

`default_nettype wire

// ==== fpu_fma_top.sv ====
// Top level of the four-lane double-precision FMA unit with issue, lanes and collector
`timescale 1ns/1ps
`default_nettype none

module fpu_fma_top (
	input  logic                        clk,
	input  logic                        rst,
	input  logic                        in_valid,
	input  fpu_pkg::fpu_op_t            in_op,
	input  fpu_pkg::reg_tag_t           in_rd,
	input  logic [63:0]                 in_a,
	input  logic [63:0]                 in_b,
	input  logic [63:0]                 in_c,
	input  logic                        flags_clear,
	output logic                        res_valid,
	output logic [63:0]                 res_value,
	output fpu_pkg::reg_tag_t           res_rd,
	output fpu_pkg::cause_t             res_cause,
	output logic [fpu_pkg::FLAG_W-1:0]  flags
);

	// Issue to lanes
	logic [fpu_pkg::NUM_LANES-1:0] start;
	logic [63:0] op_a;
	logic [63:0] op_b;
	logic [63:0] op_c;
	fpu_pkg::reg_tag_t op_rd;

	// Lanes to collector
	logic [fpu_pkg::NUM_LANES-1:0] done;
	logic [fpu_pkg::NUM_LANES-1:0][63:0] lane_result;
	fpu_pkg::cause_t [fpu_pkg::NUM_LANES-1:0] lane_cause;
	fpu_pkg::reg_tag_t [fpu_pkg::NUM_LANES-1:0] lane_rd;

	fma_issue issue_i (
		.clk      (clk),
		.rst      (rst),
		.in_valid (in_valid),
		.in_op    (in_op),
		.in_rd    (in_rd),
		.in_a     (in_a),
		.in_b     (in_b),
		.in_c     (in_c),
		.start    (start),
		.op_a     (op_a),
		.op_b     (op_b),
		.op_c     (op_c),
		.op_rd    (op_rd)
	);

	// All lanes share the operand buses and differ only in their start bit
	for (genvar k = 0; k < fpu_pkg::NUM_LANES; k++) begin : g_lane
		fma_lane lane_i (
			.clk       (clk),
			.rst       (rst),
			.start     (start[k]),
			.a         (op_a),
			.b         (op_b),
			.c         (op_c),
			.rd        (op_rd),
			.done      (done[k]),
			.busy      (),
			.result    (lane_result[k]),
			.cause     (lane_cause[k]),
			.result_rd (lane_rd[k])
		);
	end

	fma_collect collect_i (
		.clk         (clk),
		.rst         (rst),
		.done        (done),
		.lane_result (lane_result),
		.lane_cause  (lane_cause),
		.lane_rd     (lane_rd),
		.flags_clear (flags_clear),
		.res_valid   (res_valid),
		.res_value   (res_value),
		.res_rd      (res_rd),
		.res_cause   (res_cause),
		.flags       (flags)
	);

endmodule

`default_nettype wire

// ==== fpu_pkg.sv ====
// FMA unit package with opcodes, cause codes, float64 format constants and lane count
`default_nettype none

package fpu_pkg;

	// ==============================
	// Opcodes and cause codes
	// ==============================

	// Opcodes the issue block understands
	typedef enum logic [2:0] {
		OP_FADD   = 3'd0,
		OP_FSUB   = 3'd1,
		OP_FMUL   = 3'd2,
		OP_FMADD  = 3'd3,
		OP_FMSUB  = 3'd4,
		OP_FNMADD = 3'd5
	} fpu_op_t;

	// A larger code wins when several causes apply to one result
	typedef enum logic [2:0] {
		CAUSE_NONE      = 3'd0,
		CAUSE_INEXACT   = 3'd1,
		CAUSE_UNDERFLOW = 3'd2,
		CAUSE_OVERFLOW  = 3'd3,
		CAUSE_INVALID   = 3'd4
	} cause_t;

	// Sticky flag vector, one bit per cause, bit 4 is reserved and reads zero
	localparam int FLAG_W = 5;
	localparam int FLAG_INVALID = 0;
	localparam int FLAG_OVERFLOW = 1;
	localparam int FLAG_UNDERFLOW = 2;
	localparam int FLAG_INEXACT = 3;

	// Destination register number that travels with each operation
	typedef logic [4:0] reg_tag_t;

	// ==============================
	// Lanes and float64 format
	// ==============================

	localparam int NUM_LANES = 4;
	localparam int LANE_IDX_W = $clog2(NUM_LANES);
	localparam int LANE_CYCLES = 4;

	localparam int EXP_W = 11;
	localparam int MAN_W = 52;
	localparam int EXP_BIAS = 1023;

	localparam logic [63:0] F64_ONE = 64'h3FF0_0000_0000_0000;
	localparam logic [63:0] F64_NEG_ZERO = 64'h8000_0000_0000_0000;
	// Canonical quiet NaN, positive with only the quiet bit set
	localparam logic [63:0] F64_QNAN = 64'h7FF8_0000_0000_0000;

endpackage

`default_nettype wire

// ==== src.f ====
fpu_pkg.sv
fma_issue.sv
fma_lane.sv
fma_collect.sv
fpu_fma_top.sv
tb_fpu_fma.sv

// ==== tb_fpu_fma.sv ====
// Testbench for the four-lane FMA unit with reference model, in-order checker and timeout
`timescale 1ns/1ps
`default_nettype none

module tb_fpu_fma;

	localparam int RESET_CYCLES = 10;
	localparam int LATENCY = 6;
	localparam int N_BASIC = 24;
	localparam int N_FUSED = 24;
	localparam int N_STREAM = 40;
	localparam int N_SPECIAL = 4;
	localparam int TOTAL_OPS = N_BASIC + N_FUSED + N_STREAM + N_SPECIAL + 1;
	// Every test drains before the next one, so twice the busy time is plenty
	localparam int TIMEOUT_CYCLES = (TOTAL_OPS + LATENCY) * 2 + RESET_CYCLES;

	logic clk;
	logic rst;
	logic in_valid;
	fpu_pkg::fpu_op_t in_op;
	fpu_pkg::reg_tag_t in_rd;
	logic [63:0] in_a;
	logic [63:0] in_b;
	logic [63:0] in_c;
	logic flags_clear;
	logic res_valid;
	logic [63:0] res_value;
	fpu_pkg::reg_tag_t res_rd;
	fpu_pkg::cause_t res_cause;
	logic [fpu_pkg::FLAG_W-1:0] flags;

	// One pending operation as the checker expects it back
	typedef struct packed {
		logic [63:0] value;
		logic [4:0] rd;
		logic [2:0] cause;
		logic [31:0] cyc;
	} expect_t;

	expect_t exp_q[$];
	int cycle;
	int checks;
	int errors;
	logic [31:0] rng;
	fpu_pkg::reg_tag_t next_tag;

	fpu_fma_top dut_i (
		.clk         (clk),
		.rst         (rst),
		.in_valid    (in_valid),
		.in_op       (in_op),
		.in_rd       (in_rd),
		.in_a        (in_a),
		.in_b        (in_b),
		.in_c        (in_c),
		.flags_clear (flags_clear),
		.res_valid   (res_valid),
		.res_value   (res_value),
		.res_rd      (res_rd),
		.res_cause   (res_cause),
		.flags       (flags)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	always @(posedge clk) cycle <= cycle + 1;

	// ==============================
	// Reference model
	// ==============================

	function automatic logic [31:0] next_random(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	function automatic bit is_infinite(input real r);
		logic [63:0] v;
		v = $realtobits(r);
		return (v[62:52] == 11'h7FF) && (v[51:0] == '0);
	endfunction

	function automatic bit is_nan(input real r);
		logic [63:0] v;
		v = $realtobits(r);
		return (v[62:52] == 11'h7FF) && (v[51:0] != '0);
	endfunction

	// Product error by Dekker's split and sum error by two-sum decide inexactness
	// The value itself is exact here because the product is exact or the addend is zero
	function automatic void expected_result(input fpu_pkg::fpu_op_t op, input logic [63:0] a,
			input logic [63:0] b, input logic [63:0] c, output logic [63:0] val,
			output logic [2:0] cause);
		real ra, rb, rc, p, s, t, ah, al, bh, bl, bb, e_mul, e_add;
		ra = $bitstoreal(a);
		rb = $bitstoreal(b);
		rc = $bitstoreal(c);
		case (op)
			fpu_pkg::OP_FADD: rb = 1.0;
			fpu_pkg::OP_FSUB: begin
				rb = 1.0;
				rc = -rc;
			end
			fpu_pkg::OP_FMUL: rc = $bitstoreal(64'h8000_0000_0000_0000);
			fpu_pkg::OP_FMSUB: rc = -rc;
			fpu_pkg::OP_FNMADD: begin
				ra = -ra;
				rc = -rc;
			end
			default: ;
		endcase
		p = ra * rb;
		s = p + rc;
		if (is_nan(s)) begin
			val = 64'h7FF8_0000_0000_0000;
			cause = fpu_pkg::CAUSE_INVALID;
		end else if (is_infinite(s)) begin
			val = $realtobits(s);
			// An infinite operand is exact, a finite one overflowed
			if (is_infinite(ra) || is_infinite(rb) || is_infinite(rc))
				cause = fpu_pkg::CAUSE_NONE;
			else
				cause = fpu_pkg::CAUSE_OVERFLOW;
		end else begin
			t = 134217729.0 * ra;
			ah = t - (t - ra);
			al = ra - ah;
			t = 134217729.0 * rb;
			bh = t - (t - rb);
			bl = rb - bh;
			e_mul = ((ah * bh - p) + ah * bl + al * bh) + al * bl;
			bb = s - p;
			e_add = (p - (s - bb)) + (rc - bb);
			val = $realtobits(s);
			cause = (e_mul != 0.0 || e_add != 0.0) ? fpu_pkg::CAUSE_INEXACT : fpu_pkg::CAUSE_NONE;
		end
	endfunction

	// ==============================
	// Stimulus helpers
	// ==============================

	// Normal operand with exponent near the bias, short keeps 26 significant bits
	task automatic random_operand(input bit short_sig, output logic [63:0] v);
		logic [31:0] r0;
		logic [31:0] r1;
		logic [51:0] m;
		rng = next_random(rng);
		r0 = rng;
		rng = next_random(rng);
		r1 = rng;
		m = {r0[31:12], r1};
		if (short_sig)
			m[26:0] = '0;
		v = {r0[6], 11'(fpu_pkg::EXP_BIAS - 32) + 11'(r0[5:0]), m};
	endtask

	task automatic issue_op(input fpu_pkg::fpu_op_t op, input logic [63:0] a,
			input logic [63:0] b, input logic [63:0] c);
		expect_t e;
		logic [63:0] v;
		logic [2:0] cz;
		@(negedge clk);
		expected_result(op, a, b, c, v, cz);
		e.value = v;
		e.cause = cz;
		e.rd = next_tag;
		e.cyc = cycle;
		exp_q.push_back(e);
		in_valid = 1'b1;
		in_op = op;
		in_rd = next_tag;
		in_a = a;
		in_b = b;
		in_c = c;
		next_tag = next_tag + 1'b1;
	endtask

	// Stop issuing and wait until every pending result came back
	task automatic drain_results;
		@(negedge clk);
		in_valid = 1'b0;
		while (exp_q.size() != 0)
			@(negedge clk);
		repeat (3) @(negedge clk);
	endtask

	task automatic pulse_flags_clear;
		@(negedge clk);
		flags_clear = 1'b1;
		@(negedge clk);
		flags_clear = 1'b0;
	endtask

	task automatic check_flags(input logic [fpu_pkg::FLAG_W-1:0] exp, input string what);
		checks++;
		assert (flags == exp) else begin
			errors++;
			$display("[FAIL] %0t: flags %b, expected %b (%s)", $time, flags, exp, what);
		end
	endtask

	task automatic report_test(input int num, input string name, input int err_before);
		$display("test %0d %s: %s", num, name, (errors == err_before) ? "ok" : "errors");
	endtask

	// ==============================
	// Result checker
	// ==============================

	always @(negedge clk) begin
		expect_t e;
		if (!rst && res_valid) begin
			if (exp_q.size() == 0) begin
				errors++;
				$display("A result with tag %0d arrived with no operation pending", res_rd);
			end else begin
				e = exp_q.pop_front();
				checks += 4;
				assert (res_value == e.value) else begin
					errors++;
					$display("[FAIL] %0t: tag %0d value %h, expected %h", $time, e.rd,
						res_value, e.value);
				end
				assert (res_rd == e.rd) else begin
					errors++;
					$display("[FAIL] %0t: tag %0d, expected %0d", $time, res_rd, e.rd);
				end
				assert (res_cause == fpu_pkg::cause_t'(e.cause)) else begin
					errors++;
					$display("[FAIL] %0t: tag %0d cause %0d, expected %0d", $time, e.rd,
						res_cause, e.cause);
				end
				assert (cycle - int'(e.cyc) == LATENCY) else begin
					errors++;
					$display("[FAIL] %0t: tag %0d latency %0d, expected %0d", $time, e.rd,
						cycle - int'(e.cyc), LATENCY);
				end
			end
		end
	end

	initial begin
		while (cycle < TIMEOUT_CYCLES)
			@(posedge clk);
		$display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
		$display("STATUS: FAIL");
		$finish;
	end

	// ==============================
	// Test sequence
	// ==============================

	initial begin
		logic [63:0] a, b, c;
		logic [fpu_pkg::FLAG_W-1:0] fl;
		int eb;
		fpu_pkg::fpu_op_t op;
		cycle = 0;
		checks = 0;
		errors = 0;
		rng = 32'h5466eabb;
		next_tag = '0;
		rst = 1'b1;
		in_valid = 1'b0;
		in_op = fpu_pkg::OP_FADD;
		in_rd = '0;
		in_a = '0;
		in_b = '0;
		in_c = '0;
		flags_clear = 1'b0;
		repeat (RESET_CYCLES) @(negedge clk);
		rst = 1'b0;

		eb = errors;
		for (int i = 0; i < N_BASIC; i++) begin
			random_operand(1'b0, a);
			random_operand(1'b0, b);
			random_operand(1'b0, c);
			case (rng % 3)
				0: op = fpu_pkg::OP_FADD;
				1: op = fpu_pkg::OP_FSUB;
				default: op = fpu_pkg::OP_FMUL;
			endcase
			issue_op(op, a, b, c);
		end
		drain_results();
		report_test(1, "random add, sub, mul", eb);

		eb = errors;
		for (int i = 0; i < N_FUSED; i++) begin
			random_operand(1'b1, a);
			random_operand(1'b1, b);
			random_operand(1'b1, c);
			op = fpu_pkg::fpu_op_t'(3 + (rng % 3));
			issue_op(op, a, b, c);
		end
		drain_results();
		report_test(2, "random fused ops", eb);

		// Short significands keep every opcode exact in the reference
		eb = errors;
		for (int i = 0; i < N_STREAM; i++) begin
			random_operand(1'b1, a);
			random_operand(1'b1, b);
			random_operand(1'b1, c);
			op = fpu_pkg::fpu_op_t'(rng % 6);
			issue_op(op, a, b, c);
		end
		drain_results();
		report_test(3, "back-to-back issue", eb);

		eb = errors;
		pulse_flags_clear();
		issue_op(fpu_pkg::OP_FMUL, 64'h7FF0_0000_0000_0000, 64'h0, 64'h0);
		issue_op(fpu_pkg::OP_FSUB, 64'h7FF0_0000_0000_0000, 64'h0, 64'h7FF0_0000_0000_0000);
		issue_op(fpu_pkg::OP_FMUL, $realtobits(1.0e200), $realtobits(1.0e200), 64'h0);
		issue_op(fpu_pkg::OP_FMUL, 64'h8000_0000_0000_0000, 64'h3FF0_0000_0000_0000, 64'h0);
		drain_results();
		report_test(4, "special values", eb);

		eb = errors;
		fl = '0;
		fl[fpu_pkg::FLAG_INVALID] = 1'b1;
		fl[fpu_pkg::FLAG_OVERFLOW] = 1'b1;
		check_flags(fl, "after invalid and overflow");
		pulse_flags_clear();
		check_flags('0, "after clear");
		// One third times three rounds up to exactly one
		issue_op(fpu_pkg::OP_FMUL, 64'h3FD5_5555_5555_5555, 64'h4008_0000_0000_0000, 64'h0);
		drain_results();
		fl = '0;
		fl[fpu_pkg::FLAG_INEXACT] = 1'b1;
		check_flags(fl, "after inexact multiply");
		report_test(5, "sticky flags", eb);

		$display("checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("STATUS: PASS");
		else
			$display("STATUS: FAIL");
		$finish;
	end

endmodule

`default_nettype wire
